// File: Bender.yml
package:
  name: list_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/list_ctrl_pkg.sv
      - logic/tag_match.sv
      - logic/entry_state.sv
      - logic/link_table.sv
      - logic/list_ctrl.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/list_ctrl_assert.sv
      - test/list_ctrl_tb.sv

// File: logic/entry_state.sv
`timescale 1ns/1ns
`default_nettype none

`include "list_ctrl_defines.svh"

module entry_state (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      alloc_en,
    input  list_ctrl_pkg::tag_t                       alloc_tag,
    input  list_ctrl_pkg::index_t                     alloc_index,
    input  logic                                      fill_en,
    input  list_ctrl_pkg::tag_t                       fill_tag,
    output list_ctrl_pkg::status_e [`LIST_DEPTH-1:0]  entry_status,
    output list_ctrl_pkg::index_t  [`LIST_DEPTH-1:0]  entry_index
);
    import list_ctrl_pkg::*;

    for (genvar i = 0; i < `LIST_DEPTH; i++) begin : g_entry
        logic alloc_sel;
        logic fill_sel;

        assign alloc_sel = alloc_en && (alloc_tag == tag_t'(i));
        assign fill_sel  = fill_en && (fill_tag == tag_t'(i));

        // allocate wins over fill on the same entry.
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                entry_status[i] <= ST_INVALID;
            end else if (alloc_sel) begin
                entry_status[i] <= ST_FETCH;
            end else if (fill_sel) begin
                entry_status[i] <= ST_VALID;
            end
        end

        always_ff @(posedge clk) begin
            if (alloc_sel) begin
                entry_index[i] <= alloc_index; // new owner of this entry.
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/link_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "list_ctrl_defines.svh"

module link_table (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 touch_en,
    input  list_ctrl_pkg::tag_t  touch_tag,
    input  logic                 alloc_en,
    output list_ctrl_pkg::tag_t  alloc_tag
);
    import list_ctrl_pkg::*;

    typedef struct packed {
        tag_t head;
        tag_t tail;
        len_t len;
    } list_t;

    list_t lru_list;
    list_t free_list;

    // one pre/nxt pair per entry, shared by both lists.
    tag_t  pre_tag [`LIST_DEPTH];
    tag_t  nxt_tag [`LIST_DEPTH];

    logic  free_empty;
    logic  lru_empty;
    logic  take_free;
    logic  move_en;
    tag_t  move_tag;
    logic  move_is_head;
    logic  move_is_tail;

    assign free_empty = (free_list.len == '0);
    assign lru_empty  = (lru_list.len == '0);

    // free tail first, then evict the least recently used.
    assign alloc_tag = free_empty ? lru_list.tail : free_list.tail;

    assign take_free = alloc_en && !free_empty;

    // a touch and an eviction both bring an lru entry to the head.
    assign move_en  = touch_en || (alloc_en && free_empty);
    assign move_tag = touch_en ? touch_tag : lru_list.tail;

    assign move_is_head = (move_tag == lru_list.head);
    assign move_is_tail = (move_tag == lru_list.tail);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_list       <= '0;
            free_list.head <= '0;
            free_list.tail <= tag_t'(`LIST_DEPTH - 1);
            free_list.len  <= len_t'(`LIST_DEPTH);
        end else if (take_free) begin
            free_list.tail <= pre_tag[free_list.tail];
            free_list.len  <= free_list.len - 1'b1;
            lru_list.head  <= free_list.tail;
            lru_list.len   <= lru_list.len + 1'b1;
            if (lru_empty) begin
                lru_list.tail <= free_list.tail; // first entry is head and tail.
            end
        end else if (move_en && !move_is_head) begin
            lru_list.head <= move_tag;
            if (move_is_tail) begin
                lru_list.tail <= pre_tag[move_tag];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // free list starts as a ring over all entries.
            for (int i = 0; i < `LIST_DEPTH; i++) begin
                pre_tag[i] <= (i == 0) ? tag_t'(`LIST_DEPTH - 1) : tag_t'(i - 1);
                nxt_tag[i] <= (i == `LIST_DEPTH - 1) ? tag_t'(0) : tag_t'(i + 1);
            end
        end else if (take_free) begin
            if (free_list.len > len_t'(1)) begin
                // close the ring over the departing tail.
                nxt_tag[pre_tag[free_list.tail]] <= free_list.head;
                pre_tag[free_list.head]          <= pre_tag[free_list.tail];
            end
            if (!lru_empty) begin
                nxt_tag[free_list.tail] <= lru_list.head;
                pre_tag[lru_list.head]  <= free_list.tail;
            end
        end else if (move_en && !move_is_head) begin
            if (!move_is_tail) begin
                // unlink from the middle.
                nxt_tag[pre_tag[move_tag]] <= nxt_tag[move_tag];
                pre_tag[nxt_tag[move_tag]] <= pre_tag[move_tag];
            end
            nxt_tag[move_tag]      <= lru_list.head;
            pre_tag[lru_list.head] <= move_tag;
        end
    end

endmodule

`default_nettype wire

// File: logic/list_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "list_ctrl_defines.svh"

module list_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  list_ctrl_pkg::acc_req_t   acc_req,
    output list_ctrl_pkg::acc_resp_t  acc_resp
);
    import list_ctrl_pkg::*;

    logic                      rd_en;
    logic                      alloc_en;
    logic                      fill_en;
    logic                      hit;
    tag_t                      hit_tag;
    tag_t                      alloc_tag;
    logic [`LIST_DEPTH-1:0]    entry_valid;
    status_e [`LIST_DEPTH-1:0] entry_status;
    index_t  [`LIST_DEPTH-1:0] entry_index;

    // both read codes search the table.
    assign rd_en    = acc_req.req && (acc_req.cmd == CMD_READ || acc_req.cmd == CMD_READ_ALT);
    assign alloc_en = acc_req.req && (acc_req.cmd == CMD_ALLOC);
    assign fill_en  = acc_req.req && (acc_req.cmd == CMD_FILL);

    always_comb begin
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            entry_valid[i] = (entry_status[i] != ST_INVALID);
        end
    end

    tag_match u_tag_match (
        .index       (acc_req.index),
        .rd_en       (rd_en),
        .entry_valid (entry_valid),
        .entry_index (entry_index),
        .hit         (hit),
        .hit_tag     (hit_tag)
    );

    link_table u_link_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .touch_en  (hit),
        .touch_tag (hit_tag),
        .alloc_en  (alloc_en),
        .alloc_tag (alloc_tag)
    );

    entry_state u_entry_state (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_en     (alloc_en),
        .alloc_tag    (alloc_tag),
        .alloc_index  (acc_req.index),
        .fill_en      (fill_en),
        .fill_tag     (acc_req.tag),
        .entry_status (entry_status),
        .entry_index  (entry_index)
    );

    // response in the same cycle as the request.
    always_comb begin
        acc_resp.hit        = hit;
        acc_resp.status     = ST_INVALID;
        acc_resp.return_tag = '0;
        if (hit) begin
            acc_resp.status = entry_status[hit_tag];
        end
        if (alloc_en) begin
            acc_resp.return_tag = alloc_tag;
        end
    end

endmodule

`default_nettype wire

// File: logic/list_ctrl_defines.svh
`ifndef LIST_CTRL_DEFINES_SVH
`define LIST_CTRL_DEFINES_SVH

// entries held by the controller.
`define LIST_DEPTH 4

// width of the cache index searched on a read.
`define INDEX_W 4

// one tag per entry.
`define TAG_W $clog2(`LIST_DEPTH)

// list lengths run from 0 up to LIST_DEPTH, so one extra bit.
`define LEN_W (`TAG_W + 1)

`endif

// File: logic/list_ctrl_pkg.sv
`default_nettype none

`include "list_ctrl_defines.svh"

package list_ctrl_pkg;

    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [`INDEX_W-1:0] index_t;
    typedef logic [`LEN_W-1:0]   len_t;

    // access commands. both read codes do the same search.
    typedef enum logic [1:0] {
        CMD_READ     = 2'b00,
        CMD_READ_ALT = 2'b01,
        CMD_ALLOC    = 2'b10,
        CMD_FILL     = 2'b11
    } cmd_e;

    typedef enum logic [2:0] {
        ST_INVALID = 3'b000,
        ST_FETCH   = 3'b100, // allocated, data still on its way.
        ST_VALID   = 3'b001
    } status_e;

    typedef struct packed {
        logic   req;
        cmd_e   cmd;
        index_t index;
        tag_t   tag;   // only looked at by a fill.
    } acc_req_t;

    typedef struct packed {
        logic    hit;
        status_e status;
        tag_t    return_tag;
    } acc_resp_t;

endpackage

`default_nettype wire

// File: logic/tag_match.sv
`timescale 1ns/1ns
`default_nettype none

`include "list_ctrl_defines.svh"

module tag_match (
    input  list_ctrl_pkg::index_t                     index,
    input  logic                                      rd_en,
    input  logic [`LIST_DEPTH-1:0]                    entry_valid,
    input  list_ctrl_pkg::index_t [`LIST_DEPTH-1:0]   entry_index,
    output logic                                      hit,
    output list_ctrl_pkg::tag_t                       hit_tag
);
    import list_ctrl_pkg::*;

    logic [`LIST_DEPTH-1:0] match;

    // every entry compared at once.
    always_comb begin
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            match[i] = entry_valid[i] && (entry_index[i] == index);
        end
    end

    // later matches overwrite earlier ones, so the highest entry wins.
    always_comb begin
        hit     = 1'b0;
        hit_tag = '0;
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            if (rd_en && match[i]) begin
                hit     = 1'b1;
                hit_tag = tag_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: test/list_ctrl_assert.sv
`timescale 1ns/1ns
`default_nettype none

module list_ctrl_assert (
    input  logic                     clk,
    input  logic                     rst_n,
    input  list_ctrl_pkg::acc_req_t  acc_req,
    input  list_ctrl_pkg::acc_resp_t acc_resp,
    input  list_ctrl_pkg::status_e   expected_status,
    input  list_ctrl_pkg::tag_t      expected_tag
);
    import list_ctrl_pkg::*;

    int   fail_count = 0;
    logic is_read;
    logic is_alloc;
    logic is_fill;

    assign is_read  = acc_req.req && (acc_req.cmd == CMD_READ || acc_req.cmd == CMD_READ_ALT);
    assign is_alloc = acc_req.req && (acc_req.cmd == CMD_ALLOC);
    assign is_fill  = acc_req.req && (acc_req.cmd == CMD_FILL);

    a_resp_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(acc_resp))
        else begin
            fail_count = fail_count + 1;
            $error("response has unknown bits at %0t", $time);
        end

    // no request means an all-zero response.
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !acc_req.req |-> (acc_resp == '0))
        else begin
            fail_count = fail_count + 1;
            $error("error at %0t: response %h without a request", $time, $sampled(acc_resp));
        end

    a_read_hit: assert property (@(posedge clk) disable iff (!rst_n)
        is_read |-> (acc_resp.hit == (expected_status != ST_INVALID)))
        else begin
            fail_count = fail_count + 1;
            $error("error at %0t: read hit %b, expected status %s", $time,
                   $sampled(acc_resp.hit), expected_status.name());
        end

    a_read_status: assert property (@(posedge clk) disable iff (!rst_n)
        is_read |-> (acc_resp.status == expected_status && acc_resp.return_tag == '0))
        else begin
            fail_count = fail_count + 1;
            $error("error at %0t: read status %b, expected %b", $time,
                   $sampled(acc_resp.status), $sampled(expected_status));
        end

    a_alloc_tag: assert property (@(posedge clk) disable iff (!rst_n)
        is_alloc |-> (acc_resp.return_tag == expected_tag))
        else begin
            fail_count = fail_count + 1;
            $error("error at %0t: allocate returned tag %0d, expected %0d", $time,
                   $sampled(acc_resp.return_tag), $sampled(expected_tag));
        end

    // allocates and fills never report a hit.
    a_write_no_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (is_alloc || is_fill) |-> (!acc_resp.hit && acc_resp.status == ST_INVALID))
        else begin
            fail_count = fail_count + 1;
            $error("error at %0t: hit or status shown on a write command", $time);
        end

endmodule

`default_nettype wire

// File: test/list_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "list_ctrl_defines.svh"

module list_ctrl_tb;
    import list_ctrl_pkg::*;

    localparam int SEED           = 32'h3a10;
    localparam int WATCHDOG_CYCLE = 3000;
    localparam int RANDOM_OPS     = 300;
    localparam int INDEX_COUNT    = 2 ** `INDEX_W;

    logic      clk;
    logic      rst_n;
    acc_req_t  acc_req;
    acc_resp_t acc_resp;

    status_e   expected_status;
    tag_t      expected_tag;

    // reference model.
    tag_t      lru_q[$];  // head at the front.
    tag_t      free_q[$]; // tail at the back.
    status_e   model_status [`LIST_DEPTH];
    index_t    model_index  [`LIST_DEPTH];

    list_ctrl u_list_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_req  (acc_req),
        .acc_resp (acc_resp)
    );

    bind list_ctrl list_ctrl_assert u_list_ctrl_assert (
        .clk             (clk),
        .rst_n           (rst_n),
        .acc_req         (acc_req),
        .acc_resp        (acc_resp),
        .expected_status (list_ctrl_tb.expected_status),
        .expected_tag    (list_ctrl_tb.expected_tag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        for (int i = 0; i < WATCHDOG_CYCLE; i++) begin
            @(posedge clk);
        end
        $display("run did not finish within %0d cycles", WATCHDOG_CYCLE);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // highest held entry with this index, or -1.
    function automatic int find_hit(index_t idx);
        int found;
        found = -1;
        for (int t = 0; t < `LIST_DEPTH; t++) begin
            if (model_status[t] != ST_INVALID && model_index[t] == idx) begin
                found = t;
            end
        end
        return found;
    endfunction

    function automatic void move_to_head(tag_t t);
        int pos;
        pos = -1;
        for (int i = 0; i < lru_q.size(); i++) begin
            if (lru_q[i] == t) begin
                pos = i;
            end
        end
        if (pos >= 0) begin
            lru_q.delete(pos);
        end
        lru_q.push_front(t);
    endfunction

    function automatic index_t pick_fresh_index();
        index_t pool[$];
        for (int i = 0; i < INDEX_COUNT; i++) begin
            if (find_hit(index_t'(i)) < 0) begin
                pool.push_back(index_t'(i));
            end
        end
        return pool[$urandom % pool.size()];
    endfunction

    task automatic check_failures();
        if (u_list_ctrl.u_list_ctrl_assert.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure seen before %0t", $time);
        end
    endtask

    task automatic drive(cmd_e cmd, index_t idx, tag_t tag, status_e exp_status, tag_t exp_tag);
        @(negedge clk);
        check_failures();
        acc_req.req     = 1'b1;
        acc_req.cmd     = cmd;
        acc_req.index   = idx;
        acc_req.tag     = tag;
        expected_status = exp_status;
        expected_tag    = exp_tag;
    endtask

    task automatic idle();
        @(negedge clk);
        check_failures();
        acc_req = '0;
    endtask

    task automatic read_index(index_t idx);
        int      hit_t;
        status_e exp_status;
        cmd_e    cmd;
        hit_t      = find_hit(idx);
        exp_status = (hit_t >= 0) ? model_status[hit_t] : ST_INVALID;
        cmd        = ($urandom % 2) ? CMD_READ_ALT : CMD_READ;
        drive(cmd, idx, '0, exp_status, '0);
        if (hit_t >= 0) begin
            move_to_head(tag_t'(hit_t)); // a hit becomes most recent.
        end
    endtask

    task automatic allocate(index_t idx);
        tag_t t;
        if (free_q.size() > 0) begin
            t = free_q.pop_back();
            lru_q.push_front(t);
        end else begin
            t = lru_q[$]; // evict least recently used.
            move_to_head(t);
        end
        drive(CMD_ALLOC, idx, '0, ST_INVALID, t);
        model_status[t] = ST_FETCH;
        model_index[t]  = idx;
    endtask

    task automatic fill_entry(tag_t t);
        drive(CMD_FILL, index_t'($urandom), t, ST_INVALID, '0);
        model_status[t] = ST_VALID;
    endtask

    initial begin
        int   pick;
        tag_t t;
        void'($urandom(SEED));
        rst_n           = 1'b0;
        acc_req         = '0;
        expected_status = ST_INVALID;
        expected_tag    = '0;
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            free_q.push_back(tag_t'(i));
            model_status[i] = ST_INVALID;
            model_index[i]  = '0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // empty table misses everywhere.
        for (int i = 0; i < 4; i++) begin
            read_index(index_t'($urandom));
        end
        idle();

        // free list hands out tags from its tail.
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            allocate(pick_fresh_index());
        end

        // touch the oldest entry, then evict.
        read_index(model_index[`LIST_DEPTH-1]);
        allocate(pick_fresh_index());

        t = lru_q[0];
        read_index(model_index[t]);
        fill_entry(t);
        read_index(model_index[t]);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            pick = $urandom % 8;
            t    = tag_t'($urandom);
            if (pick < 2) begin
                read_index(index_t'($urandom));
            end else if (pick < 4) begin
                read_index(model_index[t]);
            end else if (pick < 6) begin
                allocate(pick_fresh_index());
            end else if (pick == 6 && model_status[t] != ST_INVALID) begin
                fill_entry(t);
            end else begin
                idle();
            end
        end

        idle();
        @(negedge clk);
        if (u_list_ctrl.u_list_ctrl_assert.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures at end of run");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/list_ctrl_pkg.sv
logic/tag_match.sv
logic/entry_state.sv
logic/link_table.sv
logic/list_ctrl.sv
test/list_ctrl_assert.sv
test/list_ctrl_tb.sv
